/* build.f */
rtl/mem_hub_pkg.sv
rtl/txrx_buffer.sv
rtl/req_dispatch.sv
rtl/mem_arbiter.sv
rtl/mem_backend.sv
rtl/mem_hub_top.sv
test/mem_hub_tb.sv

/* Makefile */
# all of these can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= mem_hub_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/mem_hub_tb.sv */
`default_nettype none

module mem_hub_tb
	import mem_hub_pkg::*;
();

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 300;
	localparam int RAM_WORDS = 2**MEM_DEPTH_W;
	// words popped over the whole run
	localparam int N_EXPECTED = 1 + BLOCK_LEN + N_PORTS * BLOCK_LEN;

	logic   clock_bus_i;
	logic   reset_i;
	port_t  port_sel_i;
	logic   req_i;
	logic   block_i;
	logic   rw_i;
	addr_t  add_i;
	logic   write_en_i;
	data_t  data_i;
	logic   read_ack_i;
	logic   req_taken_o;
	logic   ready_write_o;
	logic   ready_read_o;
	data_t  data_o;
	exc_t   exception_o;

	// reference copy of the backend ram
	data_t  ref_mem [RAM_WORDS];
	// host address of every word still to be popped
	addr_t  exp_q [$];
	addr_t  exp_addr;
	data_t  exp_word;
	int     n_checked;
	addr_t  bases [N_PORTS];
	addr_t  base;
	logic [31:0] rnd;

	mem_hub_top dut_i (
		.clock_bus_i   (clock_bus_i),
		.reset_i       (reset_i),
		.port_sel_i    (port_sel_i),
		.req_i         (req_i),
		.block_i       (block_i),
		.rw_i          (rw_i),
		.add_i         (add_i),
		.write_en_i    (write_en_i),
		.data_i        (data_i),
		.read_ack_i    (read_ack_i),
		.req_taken_o   (req_taken_o),
		.ready_write_o (ready_write_o),
		.ready_read_o  (ready_read_o),
		.data_o        (data_o),
		.exception_o   (exception_o)
	);

	always #5 clock_bus_i = ~clock_bus_i;

	// --------------------
	// helpers
	// --------------------
	// expected ram word, only the low address bits decode
	function automatic data_t ref_read(input addr_t addr);
		return ref_mem[addr[MEM_DEPTH_W-1:0]];
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	// inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clock_bus_i);
		#1;
	endtask

	task automatic apply_reset();
		reset_i = 1'b0;
		repeat (16) @(posedge clock_bus_i);
		#1;
		reset_i = 1'b1;
	endtask

	task automatic push_word(input data_t value);
		write_en_i = 1'b1;
		data_i = value;
		next_cycle();
		write_en_i = 1'b0;
	endtask

	// hold req until taken, then one idle cycle so the port unlocks
	task automatic issue_request(input port_t port, input logic blk, input logic rw,
			input addr_t addr);
		int waited;
		port_sel_i = port;
		block_i = blk;
		rw_i = rw;
		add_i = addr;
		req_i = 1'b1;
		waited = 0;
		next_cycle();
		while (!req_taken_o) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run($sformatf("timeout waiting for req_taken_o on port %0d", port));
			end
			next_cycle();
		end
		req_i = 1'b0;
		block_i = 1'b0;
		rw_i = 1'b0;
		next_cycle();
		// taken is a single pulse
		assert (!req_taken_o)
		else abort_run($sformatf("FAILED %0t: req_taken_o longer than one cycle", $time));
	endtask

	// fill the write fifo, mirror the words, then launch
	task automatic write_xfer(input port_t port, input logic blk, input addr_t addr);
		int n;
		int waited;
		data_t value;
		addr_t a;
		n = blk ? BLOCK_LEN : 1;
		port_sel_i = port;
		next_cycle();
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (!ready_write_o) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run($sformatf("timeout waiting for write room on port %0d", port));
				end
				next_cycle();
			end
			value = $urandom();
			a = addr + ADDR_W'(i);
			ref_mem[a[MEM_DEPTH_W-1:0]] = value;
			push_word(value);
		end
		issue_request(port, blk, 1'b1, addr);
	endtask

	// pop n words, queueing each expected address for the checker
	task automatic drain_words(input port_t port, input addr_t addr, input int n);
		int waited;
		port_sel_i = port;
		next_cycle();
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (!ready_read_o) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run($sformatf("timeout waiting for read data on port %0d", port));
				end
				next_cycle();
			end
			exp_q.push_back(addr + ADDR_W'(i));
			read_ack_i = 1'b1;
			next_cycle();
			read_ack_i = 1'b0;
		end
		assert (!ready_read_o)
		else abort_run($sformatf("FAILED %0t: read FIFO of port %0d not empty", $time, port));
	endtask

	task automatic expect_exception(input exc_t code);
		assert (exception_o == code)
		else abort_run($sformatf("FAILED %0t: exception_o %0h, expected %0h",
			$time, exception_o, code));
	endtask

	// --------------------
	// checker
	// --------------------
	// stable half a cycle after the drive, pop lands on the next edge
	always @(negedge clock_bus_i) begin
		if (read_ack_i && ready_read_o) begin
			assert (exp_q.size() > 0)
			else abort_run($sformatf("word popped at %0t with nothing expected", $time));
			exp_addr = exp_q.pop_front();
			exp_word = ref_read(exp_addr);
			assert (data_o === exp_word)
			else abort_run($sformatf("FAILED %0t: data_o %08h, expected %08h at address %06h",
				$time, data_o, exp_word, exp_addr));
			n_checked++;
		end
	end

	// --------------------
	// stimulus
	// --------------------
	initial begin
		void'($urandom(74));
		clock_bus_i = 1'b0;
		reset_i = 1'b0;
		port_sel_i = '0;
		req_i = 1'b0;
		block_i = 1'b0;
		rw_i = 1'b0;
		add_i = '0;
		write_en_i = 1'b0;
		data_i = '0;
		read_ack_i = 1'b0;
		n_checked = 0;
		apply_reset();
		assert (!req_taken_o)
		else abort_run($sformatf("FAILED %0t: req_taken_o high after reset", $time));
		expect_exception(EXC_NONE);

		// single word out and back through port 0
		rnd = $urandom();
		base = rnd[ADDR_W-1:0];
		write_xfer(port_t'(0), 1'b0, base);
		issue_request(port_t'(0), 1'b0, 1'b0, base);
		drain_words(port_t'(0), base, 1);

		// block written by port 1, read by port 2
		rnd = $urandom();
		base = rnd[ADDR_W-1:0];
		write_xfer(port_t'(1), 1'b1, base);
		issue_request(port_t'(2), 1'b1, 1'b0, base);
		drain_words(port_t'(2), base, BLOCK_LEN);

		// every port in turn
		for (int p = 0; p < N_PORTS; p++) begin
			rnd = $urandom();
			bases[p] = rnd[ADDR_W-1:0];
			write_xfer(port_t'(p), 1'b1, bases[p]);
		end
		// each port reads its neighbour's block, all read fifos fill first
		for (int p = 0; p < N_PORTS; p++) begin
			issue_request(port_t'(p), 1'b1, 1'b0, bases[(p + 1) % N_PORTS]);
		end
		for (int p = 0; p < N_PORTS; p++) begin
			drain_words(port_t'(p), bases[(p + 1) % N_PORTS], BLOCK_LEN);
		end
		expect_exception(EXC_NONE);

		// write fifo overflow on the last port, nothing is ever sent
		port_sel_i = port_t'(N_PORTS - 1);
		next_cycle();
		for (int i = 0; i < BLOCK_LEN; i++) begin
			push_word($urandom());
		end
		assert (!ready_write_o)
		else abort_run($sformatf("FAILED %0t: ready_write_o high with a full FIFO", $time));
		expect_exception(EXC_NONE);
		push_word($urandom());
		expect_exception(EXC_TX_OVERFLOW);

		// underflow after a fresh reset
		apply_reset();
		expect_exception(EXC_NONE);
		port_sel_i = port_t'(1);
		next_cycle();
		read_ack_i = 1'b1;
		next_cycle();
		read_ack_i = 1'b0;
		expect_exception(EXC_RX_UNDERFLOW);
		assert (!ready_read_o)
		else abort_run($sformatf("FAILED %0t: ready_read_o high on an empty port", $time));

		next_cycle();
		if (exp_q.size() == 0 && n_checked == N_EXPECTED) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run($sformatf("checked %0d words of %0d", n_checked, N_EXPECTED));
		end
	end

endmodule

`default_nettype wire

/* rtl/mem_hub_top.sv */
`default_nettype none

module mem_hub_top
	import mem_hub_pkg::*;
(
	input  wire         clock_bus_i,
	input  wire         reset_i,
	input  wire port_t  port_sel_i,
	input  wire         req_i,
	input  wire         block_i,
	input  wire         rw_i,
	input  wire addr_t  add_i,
	input  wire         write_en_i,
	input  wire data_t  data_i,
	input  wire         read_ack_i,
	output logic        req_taken_o,
	output logic        ready_write_o,
	output logic        ready_read_o,
	output data_t       data_o,
	output exc_t        exception_o
);

	// --------------------
	// dispatcher to buffers
	// --------------------
	logic  [N_PORTS-1:0]  d_req;
	logic  [N_PORTS-1:0]  d_block;
	logic  [N_PORTS-1:0]  d_rw;
	addr_t [N_PORTS-1:0]  d_add;
	logic  [N_PORTS-1:0]  d_write_en;
	data_t [N_PORTS-1:0]  d_data;
	logic  [N_PORTS-1:0]  d_read_ack;
	logic  [N_PORTS-1:0]  b_ready_write;
	logic  [N_PORTS-1:0]  b_ready_read;
	data_t [N_PORTS-1:0]  b_rdata;
	exc_t  [N_PORTS-1:0]  b_exc;

	// --------------------
	// buffers to arbiter
	// --------------------
	logic  [N_PORTS-1:0]  m_req;
	logic  [N_PORTS-1:0]  m_block;
	logic  [N_PORTS-1:0]  m_rw;
	addr_t [N_PORTS-1:0]  m_add;
	logic  [N_PORTS-1:0]  m_wvalid;
	data_t [N_PORTS-1:0]  m_wdata;
	logic  [N_PORTS-1:0]  m_clear;
	logic  [N_PORTS-1:0]  m_ready;
	logic  [N_PORTS-1:0]  m_valid;
	data_t [N_PORTS-1:0]  m_rdata;
	logic  [N_PORTS-1:0]  m_done;

	// arbiter to backend
	logic   be_req;
	logic   be_block;
	logic   be_rw;
	addr_t  be_add;
	logic   be_wvalid;
	data_t  be_wdata;
	logic   be_ready;
	logic   be_valid;
	data_t  be_rdata;
	logic   be_done;

	// launch pulse of whichever buffer won the slot
	assign req_taken_o = |m_req;

	// sticky codes of all ports merged
	always_comb begin
		exception_o = EXC_NONE;
		for (int p = 0; p < N_PORTS; p++) begin
			exception_o = exception_o | b_exc[p];
		end
	end

	req_dispatch u_dispatch (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.port_sel_i      (port_sel_i),
		.req_i           (req_i),
		.block_i         (block_i),
		.rw_i            (rw_i),
		.add_i           (add_i),
		.write_en_i      (write_en_i),
		.data_i          (data_i),
		.read_ack_i      (read_ack_i),
		.port_req_o      (d_req),
		.port_block_o    (d_block),
		.port_rw_o       (d_rw),
		.port_add_o      (d_add),
		.port_write_en_o (d_write_en),
		.port_data_o     (d_data),
		.port_read_ack_o (d_read_ack),
		.ready_write_i   (b_ready_write),
		.ready_read_i    (b_ready_read),
		.rdata_i         (b_rdata),
		.ready_write_o   (ready_write_o),
		.ready_read_o    (ready_read_o),
		.data_o          (data_o)
	);

	for (genvar g = 0; g < N_PORTS; g++) begin : g_port
		txrx_buffer u_buffer (
			.clock_bus_i   (clock_bus_i),
			.reset_i       (reset_i),
			.req_i         (d_req[g]),
			.block_i       (d_block[g]),
			.rw_i          (d_rw[g]),
			.add_i         (d_add[g]),
			.write_en_i    (d_write_en[g]),
			.data_i        (d_data[g]),
			.read_ack_i    (d_read_ack[g]),
			.ready_write_o (b_ready_write[g]),
			.ready_read_o  (b_ready_read[g]),
			.data_o        (b_rdata[g]),
			.exception_o   (b_exc[g]),
			.mem_ready_i   (m_ready[g]),
			.mem_req_o     (m_req[g]),
			.mem_block_o   (m_block[g]),
			.mem_rw_o      (m_rw[g]),
			.mem_add_o     (m_add[g]),
			.mem_wvalid_o  (m_wvalid[g]),
			.mem_wdata_o   (m_wdata[g]),
			.mem_valid_i   (m_valid[g]),
			.mem_rdata_i   (m_rdata[g]),
			.mem_done_i    (m_done[g]),
			.mem_clear_o   (m_clear[g])
		);
	end

	mem_arbiter u_arbiter (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.req_i       (m_req),
		.block_i     (m_block),
		.rw_i        (m_rw),
		.add_i       (m_add),
		.wvalid_i    (m_wvalid),
		.wdata_i     (m_wdata),
		.clear_i     (m_clear),
		.ready_o     (m_ready),
		.valid_o     (m_valid),
		.rdata_o     (m_rdata),
		.done_o      (m_done),
		.be_req_o    (be_req),
		.be_block_o  (be_block),
		.be_rw_o     (be_rw),
		.be_add_o    (be_add),
		.be_wvalid_o (be_wvalid),
		.be_wdata_o  (be_wdata),
		.be_ready_i  (be_ready),
		.be_valid_i  (be_valid),
		.be_rdata_i  (be_rdata),
		.be_done_i   (be_done)
	);

	mem_backend u_backend (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.be_req_i    (be_req),
		.be_block_i  (be_block),
		.be_rw_i     (be_rw),
		.be_add_i    (be_add),
		.be_wvalid_i (be_wvalid),
		.be_wdata_i  (be_wdata),
		.be_ready_o  (be_ready),
		.be_valid_o  (be_valid),
		.be_rdata_o  (be_rdata),
		.be_done_o   (be_done)
	);

endmodule

`default_nettype wire

/* rtl/mem_backend.sv */
`default_nettype none

module mem_backend
	import mem_hub_pkg::*;
(
	input  wire         clock_bus_i,
	input  wire         reset_i,
	input  wire         be_req_i,
	input  wire         be_block_i,
	input  wire         be_rw_i,
	input  wire addr_t  be_add_i,
	input  wire         be_wvalid_i,
	input  wire data_t  be_wdata_i,
	output logic        be_ready_o,
	output logic        be_valid_o,
	output data_t       be_rdata_o,
	output logic        be_done_o
);

	// word ram, low address bits only
	data_t                    ram [2**MEM_DEPTH_W];
	be_state_t                state;
	// word address, wraps inside the ram
	logic [MEM_DEPTH_W-1:0]   ptr;
	// words left in the transfer
	logic [CNT_W-1:0]         cnt;
	logic                     last;

	assign be_ready_o = (state == BE_IDLE);
	assign be_valid_o = (state == BE_READ);
	assign be_rdata_o = ram[ptr];
	assign be_done_o = (state == BE_DONE);
	assign last = (cnt == CNT_W'(1));

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state <= BE_IDLE;
			ptr <= '0;
			cnt <= '0;
		end else begin
			case (state)
				BE_IDLE: begin
					if (be_req_i) begin
						ptr <= be_add_i[MEM_DEPTH_W-1:0];
						cnt <= be_block_i ? CNT_W'(BLOCK_LEN) : CNT_W'(1);
						state <= be_rw_i ? BE_WRITE : BE_READ;
					end
				end
				// one word per strobe
				BE_WRITE: begin
					if (be_wvalid_i) begin
						ptr <= ptr + 1'b1;
						cnt <= cnt - 1'b1;
						if (last) begin
							state <= BE_DONE;
						end
					end
				end
				// one word every cycle
				BE_READ: begin
					ptr <= ptr + 1'b1;
					cnt <= cnt - 1'b1;
					if (last) begin
						state <= BE_DONE;
					end
				end
				BE_DONE: state <= BE_IDLE;
				default: state <= BE_IDLE;
			endcase
		end
	end

	// ram write port
	always_ff @(posedge clock_bus_i) begin
		if ((state == BE_WRITE) && be_wvalid_i) begin
			ram[ptr] <= be_wdata_i;
		end
	end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`default_nettype none

module mem_arbiter
	import mem_hub_pkg::*;
(
	input  wire                        clock_bus_i,
	input  wire                        reset_i,
	// buffer side, one lane per port
	input  wire   [N_PORTS-1:0]        req_i,
	input  wire   [N_PORTS-1:0]        block_i,
	input  wire   [N_PORTS-1:0]        rw_i,
	input  wire addr_t [N_PORTS-1:0]   add_i,
	input  wire   [N_PORTS-1:0]        wvalid_i,
	input  wire data_t [N_PORTS-1:0]   wdata_i,
	input  wire   [N_PORTS-1:0]        clear_i,
	output logic  [N_PORTS-1:0]        ready_o,
	output logic  [N_PORTS-1:0]        valid_o,
	output data_t [N_PORTS-1:0]        rdata_o,
	output logic  [N_PORTS-1:0]        done_o,
	// backend side
	output logic                       be_req_o,
	output logic                       be_block_o,
	output logic                       be_rw_o,
	output addr_t                      be_add_o,
	output logic                       be_wvalid_o,
	output data_t                      be_wdata_o,
	input  wire                        be_ready_i,
	input  wire                        be_valid_i,
	input  wire data_t                 be_rdata_i,
	input  wire                        be_done_i
);

	arb_state_t state;
	// port offered a slot this cycle
	port_t      offer;
	// port offered last cycle, then holder of the grant
	port_t      owner;
	logic       offer_ok;
	logic       busy;

	assign busy = (state == ARB_BUSY);
	// no offer while a launch is landing or the last owner retires
	assign offer_ok = !busy && be_ready_i && !(|req_i) && !(|clear_i);

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state <= ARB_IDLE;
			offer <= '0;
			owner <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (req_i[owner]) begin
						state <= ARB_BUSY;
						offer <= owner + 1'b1;
					end else begin
						// rotate every idle cycle
						owner <= offer;
						offer <= offer + 1'b1;
					end
				end
				ARB_BUSY: begin
					if (be_done_i) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// --------------------
	// owner mux toward the backend
	// --------------------
	assign be_req_o = !busy && req_i[owner];
	assign be_block_o = block_i[owner];
	assign be_rw_o = rw_i[owner];
	assign be_add_o = add_i[owner];
	assign be_wvalid_o = busy && wvalid_i[owner];
	assign be_wdata_o = wdata_i[owner];

	// responses only reach the owner
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			ready_o[i] = offer_ok && (offer == port_t'(i));
			valid_o[i] = busy && be_valid_i && (owner == port_t'(i));
			rdata_o[i] = (owner == port_t'(i)) ? be_rdata_i : '0;
			done_o[i] = busy && be_done_i && (owner == port_t'(i));
		end
	end

endmodule

`default_nettype wire

/* rtl/req_dispatch.sv */
`default_nettype none

module req_dispatch
	import mem_hub_pkg::*;
(
	input  wire                        clock_bus_i,
	input  wire                        reset_i,
	// host side
	input  wire port_t                 port_sel_i,
	input  wire                        req_i,
	input  wire                        block_i,
	input  wire                        rw_i,
	input  wire addr_t                 add_i,
	input  wire                        write_en_i,
	input  wire data_t                 data_i,
	input  wire                        read_ack_i,
	// one lane per buffer
	output logic  [N_PORTS-1:0]        port_req_o,
	output logic  [N_PORTS-1:0]        port_block_o,
	output logic  [N_PORTS-1:0]        port_rw_o,
	output addr_t [N_PORTS-1:0]        port_add_o,
	output logic  [N_PORTS-1:0]        port_write_en_o,
	output data_t [N_PORTS-1:0]        port_data_o,
	output logic  [N_PORTS-1:0]        port_read_ack_o,
	input  wire   [N_PORTS-1:0]        ready_write_i,
	input  wire   [N_PORTS-1:0]        ready_read_i,
	input  wire data_t [N_PORTS-1:0]   rdata_i,
	// levels and data of the selected port
	output logic                       ready_write_o,
	output logic                       ready_read_o,
	output data_t                      data_o
);

	port_t sel_q;
	port_t sel;
	// a request was held in the last cycle
	logic  locked;

	// port is frozen while a request stays pending
	assign sel = locked ? sel_q : port_sel_i;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			sel_q <= '0;
			locked <= 1'b0;
		end else begin
			sel_q <= sel;
			locked <= req_i;
		end
	end

	// one-hot strobes, other lanes held at 0
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			port_req_o[i] = req_i && (sel == port_t'(i));
			port_block_o[i] = block_i && (sel == port_t'(i));
			port_rw_o[i] = rw_i && (sel == port_t'(i));
			port_write_en_o[i] = write_en_i && (sel == port_t'(i));
			port_read_ack_o[i] = read_ack_i && (sel == port_t'(i));
			port_add_o[i] = add_i;
			port_data_o[i] = data_i;
		end
	end

	// return path
	assign ready_write_o = ready_write_i[sel];
	assign ready_read_o = ready_read_i[sel];
	assign data_o = rdata_i[sel];

endmodule

`default_nettype wire

/* rtl/txrx_buffer.sv */
`default_nettype none

module txrx_buffer
	import mem_hub_pkg::*;
(
	input  wire         clock_bus_i,
	input  wire         reset_i,
	// host side, already routed to this port
	input  wire         req_i,
	input  wire         block_i,
	input  wire         rw_i,
	input  wire addr_t  add_i,
	input  wire         write_en_i,
	input  wire data_t  data_i,
	input  wire         read_ack_i,
	output logic        ready_write_o,
	output logic        ready_read_o,
	output data_t       data_o,
	output exc_t        exception_o,
	// memory side, through the arbiter
	input  wire         mem_ready_i,
	output logic        mem_req_o,
	output logic        mem_block_o,
	output logic        mem_rw_o,
	output addr_t       mem_add_o,
	output logic        mem_wvalid_o,
	output data_t       mem_wdata_o,
	input  wire         mem_valid_i,
	input  wire data_t  mem_rdata_i,
	input  wire         mem_done_i,
	output logic        mem_clear_o
);

	// --------------------
	// write fifo and request launch
	// --------------------
	data_t              tx_mem [BLOCK_LEN];
	logic [CNT_W-2:0]   tx_wr_ptr;
	logic [CNT_W-2:0]   tx_rd_ptr;
	// words held but not yet sent
	logic [CNT_W-1:0]   n_in;
	// words still owed to the current write transfer
	logic [CNT_W-1:0]   n_tx;
	logic               tx_push;
	logic               tx_pop;
	logic               req_go;
	exc_t               tx_exc;

	assign ready_write_o = (n_in != CNT_W'(BLOCK_LEN));
	assign tx_push = write_en_i && ready_write_o;
	// stream only while words are both owed and present
	assign tx_pop = (n_tx != '0) && (n_in != '0);
	// launch when the arbiter offers this port a slot
	assign req_go = req_i && mem_ready_i;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			tx_wr_ptr <= '0;
			tx_rd_ptr <= '0;
			n_in <= '0;
			n_tx <= '0;
			mem_req_o <= 1'b0;
			mem_block_o <= 1'b0;
			mem_rw_o <= 1'b0;
			mem_wvalid_o <= 1'b0;
			tx_exc <= EXC_NONE;
		end else begin
			mem_req_o <= req_go;
			mem_wvalid_o <= tx_pop;
			if (req_go) begin
				mem_block_o <= block_i;
				mem_rw_o <= rw_i;
			end
			// write launch arms the stream count, 1 or a block
			if (req_go && rw_i) begin
				n_tx <= block_i ? CNT_W'(BLOCK_LEN) : CNT_W'(1);
			end else if (tx_pop) begin
				n_tx <= n_tx - 1'b1;
			end
			n_in <= n_in + CNT_W'(tx_push) - CNT_W'(tx_pop);
			if (tx_push) begin
				tx_wr_ptr <= tx_wr_ptr + 1'b1;
			end
			if (tx_pop) begin
				tx_rd_ptr <= tx_rd_ptr + 1'b1;
			end
			// write into a full fifo is dropped and flagged
			if (write_en_i && !ready_write_o) begin
				tx_exc <= tx_exc | EXC_TX_OVERFLOW;
			end
		end
	end

	// payload path
	always_ff @(posedge clock_bus_i) begin
		if (req_go) begin
			mem_add_o <= add_i;
		end
		if (tx_push) begin
			tx_mem[tx_wr_ptr] <= data_i;
		end
		if (tx_pop) begin
			mem_wdata_o <= tx_mem[tx_rd_ptr];
		end
	end

	// --------------------
	// read fifo
	// --------------------
	data_t              rx_mem [BLOCK_LEN];
	logic [CNT_W-2:0]   rx_wr_ptr;
	logic [CNT_W-2:0]   rx_rd_ptr;
	logic [CNT_W-1:0]   n_rx;
	logic               rx_push;
	logic               rx_pop;
	exc_t               rx_exc;

	assign ready_read_o = (n_rx != '0);
	assign data_o = rx_mem[rx_rd_ptr];
	assign rx_push = mem_valid_i && (n_rx != CNT_W'(BLOCK_LEN));
	assign rx_pop = read_ack_i && ready_read_o;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			rx_wr_ptr <= '0;
			rx_rd_ptr <= '0;
			n_rx <= '0;
			rx_exc <= EXC_NONE;
			mem_clear_o <= 1'b0;
		end else begin
			n_rx <= n_rx + CNT_W'(rx_push) - CNT_W'(rx_pop);
			if (rx_push) begin
				rx_wr_ptr <= rx_wr_ptr + 1'b1;
			end
			if (rx_pop) begin
				rx_rd_ptr <= rx_rd_ptr + 1'b1;
			end
			// returned word with no room left
			if (mem_valid_i && !rx_push) begin
				rx_exc <= rx_exc | EXC_RX_OVERFLOW;
			end
			// ack with nothing to read
			if (read_ack_i && !ready_read_o) begin
				rx_exc <= rx_exc | EXC_RX_UNDERFLOW;
			end
			// retire the transfer one cycle after done
			mem_clear_o <= mem_done_i;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (rx_push) begin
			rx_mem[rx_wr_ptr] <= mem_rdata_i;
		end
	end

	assign exception_o = tx_exc | rx_exc;

endmodule

`default_nettype wire

/* rtl/mem_hub_pkg.sv */
`default_nettype none

// sizes, word types and exception codes for the memory hub
package mem_hub_pkg;

	// --------------------
	// sizes
	// --------------------
	// client ports and the width of their index
	localparam int N_PORTS = 4;
	localparam int PORT_W = 2;

	// host word and request address
	localparam int DATA_W = 32;
	localparam int ADDR_W = 24;

	// backend decodes 256 words
	localparam int MEM_DEPTH_W = 8;

	// block length, also the depth of every fifo
	localparam int BLOCK_LEN = 16;
	// fill counter, one bit wider than a pointer
	localparam int CNT_W = 5;

	// --------------------
	// types
	// --------------------
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PORT_W-1:0] port_t;
	typedef logic [3:0] exc_t;

	// sticky exception codes, one bit each
	localparam exc_t EXC_NONE = 4'd0;
	localparam exc_t EXC_TX_OVERFLOW = 4'd1;
	localparam exc_t EXC_RX_UNDERFLOW = 4'd2;
	localparam exc_t EXC_RX_OVERFLOW = 4'd4;

	// arbiter and backend fsm states
	typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;
	typedef enum logic [1:0] {BE_IDLE, BE_WRITE, BE_READ, BE_DONE} be_state_t;

endpackage

`default_nettype wire
